// ==== mem_pkg.sv ====
package mem_pkg;

    // entry geometry
    localparam int entry_bits = 64;
    localparam int byte_bits  = 8;
    localparam int mask_bits  = entry_bits / byte_bits;
    localparam int num_sets   = 64;
    localparam int set_bits   = $clog2(num_sets);

    // set address plus byte offset within an entry
    localparam int addr_bits  = set_bits + $clog2(mask_bits);

    typedef enum logic [3:0]
    {
        op_lb  = 4'd0,
        op_lbu = 4'd1,
        op_lh  = 4'd2,
        op_lhu = 4'd3,
        op_lw  = 4'd4,
        op_lwu = 4'd5,
        op_ld  = 4'd6,
        op_sb  = 4'd8,
        op_sh  = 4'd9,
        op_sw  = 4'd10,
        op_sd  = 4'd11
    } mem_op_e;

    // load info carried one cycle alongside the RAM read
    typedef struct packed
    {
        logic       is_load;
        logic [1:0] size_log2;
        logic       is_signed;
        logic [2:0] byte_offset;
    } ld_info_t;

endpackage

// ==== mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if;
    import mem_pkg::*;

    logic                  access_en;
    logic [mask_bits-1:0]  write_en;
    logic [set_bits-1:0]   set_addr;
    logic [entry_bits-1:0] write_entry;

    modport src
    (
        output access_en,
        output write_en,
        output set_addr,
        output write_entry
    );

    modport sink
    (
        input access_en,
        input write_en,
        input set_addr,
        input write_entry
    );

endinterface

// ==== access_decoder.sv ====
`timescale 1ns/1ps

module access_decoder
(
    input  logic                           req,
    input  mem_pkg::mem_op_e               op,
    input  logic [mem_pkg::addr_bits-1:0]  addr,
    input  logic [mem_pkg::entry_bits-1:0] wdata,
    mem_req_if.src                         req_port,
    output mem_pkg::ld_info_t              info
);
    import mem_pkg::*;

    logic           is_load;
    logic           is_store;
    logic           is_signed;
    logic [1:0]     size_log2;
    logic [2:0]     byte_offset;
    logic [mask_bits-1:0] size_lanes;

    always_comb
    begin
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_signed = 1'b0;
        size_log2 = 2'd0;
        case (op)
            op_lb:  begin is_load = 1'b1; is_signed = 1'b1; size_log2 = 2'd0; end
            op_lbu: begin is_load = 1'b1; size_log2 = 2'd0; end
            op_lh:  begin is_load = 1'b1; is_signed = 1'b1; size_log2 = 2'd1; end
            op_lhu: begin is_load = 1'b1; size_log2 = 2'd1; end
            op_lw:  begin is_load = 1'b1; is_signed = 1'b1; size_log2 = 2'd2; end
            op_lwu: begin is_load = 1'b1; size_log2 = 2'd2; end
            op_ld:  begin is_load = 1'b1; size_log2 = 2'd3; end
            op_sb:  begin is_store = 1'b1; size_log2 = 2'd0; end
            op_sh:  begin is_store = 1'b1; size_log2 = 2'd1; end
            op_sw:  begin is_store = 1'b1; size_log2 = 2'd2; end
            op_sd:  begin is_store = 1'b1; size_log2 = 2'd3; end
            default: ;
        endcase
    end

    // drop offset bits below the access size
    assign byte_offset = addr[2:0] & (3'b111 << size_log2);

    always_comb
    begin
        case (size_log2)
            2'd0:    size_lanes = 8'h01;
            2'd1:    size_lanes = 8'h03;
            2'd2:    size_lanes = 8'h0f;
            default: size_lanes = 8'hff;
        endcase
    end

    // low store bytes copied into every lane group of that size
    always_comb
    begin
        case (size_log2)
            2'd0:    req_port.write_entry = {8{wdata[7:0]}};
            2'd1:    req_port.write_entry = {4{wdata[15:0]}};
            2'd2:    req_port.write_entry = {2{wdata[31:0]}};
            default: req_port.write_entry = wdata;
        endcase
    end

    assign req_port.access_en = req;
    assign req_port.set_addr  = addr[addr_bits-1 -: set_bits];
    assign req_port.write_en  = (req && is_store) ? (size_lanes << byte_offset) : '0;

    assign info.is_load     = is_load;
    assign info.size_log2   = size_log2;
    assign info.is_signed   = is_signed;
    assign info.byte_offset = byte_offset;

endmodule

// ==== dual_port_blockram.sv ====
`timescale 1ns/1ps

// port A wins when both ports write the same set

module dual_port_blockram
#(
    parameter int entry_width      = mem_pkg::entry_bits,
    parameter int num_set          = mem_pkg::num_sets,
    parameter     config_mode      = "write_first",
    parameter bit with_valid_array = 1'b1
)
(
    input  logic                   clk_in,
    input  logic                   reset_in,
    mem_req_if.sink                port_a,
    mem_req_if.sink                port_b,
    output logic [entry_width-1:0] port_a_read_entry,
    output logic [entry_width-1:0] port_b_read_entry,
    output logic                   port_a_read_valid,
    output logic                   port_b_read_valid
);
    import mem_pkg::*;

    localparam int mask_len = entry_width / byte_bits;

    logic [entry_width-1:0] mem_array [num_set];

    logic                   a_wr;
    logic                   b_wr;
    logic                   same_set;
    logic                   b_drop;
    logic                   fwd_a_to_b;
    logic                   fwd_b_to_a;
    logic [entry_width-1:0] a_bit_mask;
    logic [entry_width-1:0] b_bit_mask;
    logic [entry_width-1:0] a_masked;
    logic [entry_width-1:0] b_masked;
    logic [entry_width-1:0] a_stored;
    logic [entry_width-1:0] b_stored;
    logic                   a_set_valid;
    logic                   b_set_valid;
    logic [entry_width-1:0] a_next_entry;
    logic [entry_width-1:0] b_next_entry;
    logic                   a_next_hit;
    logic                   b_next_hit;

    assign a_wr     = port_a.access_en && (|port_a.write_en);
    assign b_wr     = port_b.access_en && (|port_b.write_en);
    assign same_set = port_a.set_addr == port_b.set_addr;

    // port B store lost whole on a same-set clash
    assign b_drop     = a_wr && b_wr && same_set;
    assign fwd_a_to_b = a_wr && same_set;
    assign fwd_b_to_a = b_wr && same_set && !a_wr;

    always_comb
    begin
        for (int i = 0; i < entry_width; i++)
        begin
            a_bit_mask[i] = port_a.write_en[i / byte_bits];
            b_bit_mask[i] = port_b.write_en[i / byte_bits];
        end
    end

    assign a_masked = port_a.write_entry & a_bit_mask;
    assign b_masked = port_b.write_entry & b_bit_mask;
    assign a_stored = mem_array[port_a.set_addr];
    assign b_stored = mem_array[port_b.set_addr];

    // A lanes written last so they win
    always_ff @(posedge clk_in)
    begin
        for (int lane = 0; lane < mask_len; lane++)
        begin
            if (b_wr && !b_drop && port_b.write_en[lane])
            begin
                mem_array[port_b.set_addr][lane*byte_bits +: byte_bits]
                    <= port_b.write_entry[lane*byte_bits +: byte_bits];
            end
            if (a_wr && port_a.write_en[lane])
            begin
                mem_array[port_a.set_addr][lane*byte_bits +: byte_bits]
                    <= port_a.write_entry[lane*byte_bits +: byte_bits];
            end
        end
    end

    if (with_valid_array) begin : g_valid
        logic [num_set-1:0] valid_bits;

        always_ff @(posedge clk_in)
        begin
            if (reset_in)
            begin
                valid_bits <= '0;
            end
            else
            begin
                if (a_wr)
                begin
                    valid_bits[port_a.set_addr] <= 1'b1;
                end
                if (b_wr && !b_drop)
                begin
                    valid_bits[port_b.set_addr] <= 1'b1;
                end
            end
        end

        assign a_set_valid = valid_bits[port_a.set_addr];
        assign b_set_valid = valid_bits[port_b.set_addr];
    end
    else begin : g_no_valid
        // every set counts as written
        assign a_set_valid = 1'b1;
        assign b_set_valid = 1'b1;
    end

    if (config_mode == "write_first") begin : g_write_first
        // same-cycle writes show through, unwritten lanes zero
        assign a_next_entry = a_wr ? a_masked : (fwd_b_to_a ? b_masked : a_stored);
        assign b_next_entry = fwd_a_to_b ? a_masked : (b_wr ? b_masked : b_stored);
        assign a_next_hit   = a_set_valid | a_wr | fwd_b_to_a;
        assign b_next_hit   = b_set_valid | b_wr | fwd_a_to_b;
    end
    else begin : g_read_first
        assign a_next_entry = a_stored;
        assign b_next_entry = b_stored;
        assign a_next_hit   = a_set_valid;
        assign b_next_hit   = b_set_valid;
    end

    always_ff @(posedge clk_in)
    begin
        if (port_a.access_en)
        begin
            port_a_read_entry <= a_next_entry;
        end
        if (port_b.access_en)
        begin
            port_b_read_entry <= b_next_entry;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            port_a_read_valid <= 1'b0;
            port_b_read_valid <= 1'b0;
        end
        else
        begin
            port_a_read_valid <= port_a.access_en && a_next_hit;
            port_b_read_valid <= port_b.access_en && b_next_hit;
        end
    end

endmodule

// ==== load_formatter.sv ====
`timescale 1ns/1ps

module load_formatter
(
    input  logic                           clk_in,
    input  logic                           reset_in,
    input  logic                           access,
    input  mem_pkg::ld_info_t              info,
    input  logic [mem_pkg::entry_bits-1:0] read_entry,
    input  logic                           read_valid,
    output logic                           rsp_valid,
    output logic [mem_pkg::entry_bits-1:0] rsp_data,
    output logic                           rsp_hit
);
    import mem_pkg::*;

    logic                          access_q;
    ld_info_t                      info_q;
    logic [$clog2(entry_bits)-1:0] lane_shift;
    logic [entry_bits-1:0]         shifted;
    logic                          sign_bit;

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            access_q <= 1'b0;
        end
        else
        begin
            access_q <= access;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (access)
        begin
            info_q <= info;
        end
    end

    // byte offset times eight
    assign lane_shift = {info_q.byte_offset, 3'b000};
    assign shifted    = read_entry >> lane_shift;

    always_comb
    begin
        case (info_q.size_log2)
            2'd0:    sign_bit = shifted[byte_bits-1];
            2'd1:    sign_bit = shifted[2*byte_bits-1];
            2'd2:    sign_bit = shifted[4*byte_bits-1];
            default: sign_bit = shifted[entry_bits-1];
        endcase
        sign_bit = sign_bit & info_q.is_signed;

        case (info_q.size_log2)
            2'd0:    rsp_data = {{56{sign_bit}}, shifted[7:0]};
            2'd1:    rsp_data = {{48{sign_bit}}, shifted[15:0]};
            2'd2:    rsp_data = {{32{sign_bit}}, shifted[31:0]};
            default: rsp_data = shifted;
        endcase
    end

    assign rsp_valid = access_q && info_q.is_load;
    assign rsp_hit   = rsp_valid && read_valid;

endmodule

// ==== scratchpad_top.sv ====
`timescale 1ns/1ps

module scratchpad_top
(
    input  logic                           clk_in,
    input  logic                           reset_in,

    input  logic                           a_req,
    input  mem_pkg::mem_op_e               a_op,
    input  logic [mem_pkg::addr_bits-1:0]  a_addr,
    input  logic [mem_pkg::entry_bits-1:0] a_wdata,
    output logic                           a_rsp_valid,
    output logic [mem_pkg::entry_bits-1:0] a_rsp_data,
    output logic                           a_rsp_hit,

    input  logic                           b_req,
    input  mem_pkg::mem_op_e               b_op,
    input  logic [mem_pkg::addr_bits-1:0]  b_addr,
    input  logic [mem_pkg::entry_bits-1:0] b_wdata,
    output logic                           b_rsp_valid,
    output logic [mem_pkg::entry_bits-1:0] b_rsp_data,
    output logic                           b_rsp_hit
);
    import mem_pkg::*;

    ld_info_t              info_a;
    ld_info_t              info_b;
    logic [entry_bits-1:0] read_entry_a;
    logic [entry_bits-1:0] read_entry_b;
    logic                  read_valid_a;
    logic                  read_valid_b;

    mem_req_if req_a ();
    mem_req_if req_b ();

    access_decoder u_dec_a
    (
        .req      (a_req),
        .op       (a_op),
        .addr     (a_addr),
        .wdata    (a_wdata),
        .req_port (req_a),
        .info     (info_a)
    );

    access_decoder u_dec_b
    (
        .req      (b_req),
        .op       (b_op),
        .addr     (b_addr),
        .wdata    (b_wdata),
        .req_port (req_b),
        .info     (info_b)
    );

    dual_port_blockram
    #(
        .entry_width      (entry_bits),
        .num_set          (num_sets),
        .config_mode      ("write_first"),
        .with_valid_array (1'b1)
    )
    u_ram
    (
        .clk_in            (clk_in),
        .reset_in          (reset_in),
        .port_a            (req_a),
        .port_b            (req_b),
        .port_a_read_entry (read_entry_a),
        .port_b_read_entry (read_entry_b),
        .port_a_read_valid (read_valid_a),
        .port_b_read_valid (read_valid_b)
    );

    load_formatter u_fmt_a
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .access     (a_req),
        .info       (info_a),
        .read_entry (read_entry_a),
        .read_valid (read_valid_a),
        .rsp_valid  (a_rsp_valid),
        .rsp_data   (a_rsp_data),
        .rsp_hit    (a_rsp_hit)
    );

    load_formatter u_fmt_b
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .access     (b_req),
        .info       (info_b),
        .read_entry (read_entry_b),
        .read_valid (read_valid_b),
        .rsp_valid  (b_rsp_valid),
        .rsp_data   (b_rsp_data),
        .rsp_hit    (b_rsp_hit)
    );

endmodule

// ==== scratchpad_props.sv ====
`timescale 1ns/1ps

module scratchpad_props
(
    input logic             clk_in,
    input logic             reset_in,
    input logic             a_req,
    input mem_pkg::mem_op_e a_op,
    input logic             a_rsp_valid,
    input logic             a_rsp_hit,
    input logic             b_req,
    input mem_pkg::mem_op_e b_op,
    input logic             b_rsp_valid,
    input logic             b_rsp_hit
);
    import mem_pkg::*;

    logic a_load;
    logic b_load;

    assign a_load = a_req && (a_op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld});
    assign b_load = b_req && (b_op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld});

    // response exactly one cycle after a load
    a_rsp_after_load: assert property (@(posedge clk_in) disable iff (reset_in)
        a_rsp_valid |-> $past(a_load))
        else $error("port A response without a load one cycle earlier");

    b_rsp_after_load: assert property (@(posedge clk_in) disable iff (reset_in)
        b_rsp_valid |-> $past(b_load))
        else $error("port B response without a load one cycle earlier");

    rsp_low_after_reset: assert property (@(posedge clk_in)
        reset_in |=> !a_rsp_valid && !a_rsp_hit && !b_rsp_valid && !b_rsp_hit)
        else $error("response outputs high in the cycle after reset");

    a_rsp_needs_req: assert property (@(posedge clk_in) disable iff (reset_in)
        a_rsp_valid |-> $past(a_req))
        else $error("port A response without a prior request");

    b_rsp_needs_req: assert property (@(posedge clk_in) disable iff (reset_in)
        b_rsp_valid |-> $past(b_req))
        else $error("port B response without a prior request");

endmodule

bind scratchpad_top scratchpad_props u_props
(
    .clk_in      (clk_in),
    .reset_in    (reset_in),
    .a_req       (a_req),
    .a_op        (a_op),
    .a_rsp_valid (a_rsp_valid),
    .a_rsp_hit   (a_rsp_hit),
    .b_req       (b_req),
    .b_op        (b_op),
    .b_rsp_valid (b_rsp_valid),
    .b_rsp_hit   (b_rsp_hit)
);

// ==== scratchpad_tb.sv ====
`timescale 1ns/1ps

module scratchpad_tb;
    import mem_pkg::*;

    // about 1380 cycles of traffic plus margin
    localparam int timeout_cycles = 2000;

    logic                  clk_in;
    logic                  reset_in;
    logic                  a_req;
    mem_op_e               a_op;
    logic [addr_bits-1:0]  a_addr;
    logic [entry_bits-1:0] a_wdata;
    logic                  a_rsp_valid;
    logic [entry_bits-1:0] a_rsp_data;
    logic                  a_rsp_hit;
    logic                  b_req;
    mem_op_e               b_op;
    logic [addr_bits-1:0]  b_addr;
    logic [entry_bits-1:0] b_wdata;
    logic                  b_rsp_valid;
    logic [entry_bits-1:0] b_rsp_data;
    logic                  b_rsp_hit;

    // reference model
    logic [entry_bits-1:0] model_mem [num_sets];
    logic                  model_written [num_sets];

    // response owed for the request driven one cycle earlier
    logic                  exp_a_valid;
    logic                  exp_a_hit;
    logic [entry_bits-1:0] exp_a_data;
    logic                  exp_b_valid;
    logic                  exp_b_hit;
    logic [entry_bits-1:0] exp_b_data;

    int seed;
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;

    mem_op_e op_table [11] = '{op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld,
                               op_sb, op_sh, op_sw, op_sd};

    scratchpad_top dut
    (
        .clk_in      (clk_in),
        .reset_in    (reset_in),
        .a_req       (a_req),
        .a_op        (a_op),
        .a_addr      (a_addr),
        .a_wdata     (a_wdata),
        .a_rsp_valid (a_rsp_valid),
        .a_rsp_data  (a_rsp_data),
        .a_rsp_hit   (a_rsp_hit),
        .b_req       (b_req),
        .b_op        (b_op),
        .b_addr      (b_addr),
        .b_wdata     (b_wdata),
        .b_rsp_valid (b_rsp_valid),
        .b_rsp_data  (b_rsp_data),
        .b_rsp_hit   (b_rsp_hit)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    always @(posedge clk_in)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        return int'(rand_word() % n);
    endfunction

    function automatic logic [entry_bits-1:0] rand_data();
        return {rand_word(), rand_word()};
    endfunction

    function automatic logic [addr_bits-1:0] make_addr(input int set, input int off);
        return addr_bits'(set * mask_bits + off);
    endfunction

    // kind 1 picks a load, kind 2 a store, anything else either
    function automatic mem_op_e pick_op(input int kind);
        if (kind == 1)
            return op_table[rand_below(7)];
        else if (kind == 2)
            return op_table[7 + rand_below(4)];
        else
            return op_table[rand_below(11)];
    endfunction

    function automatic int size_bytes(input mem_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return 1;
            op_lh, op_lhu, op_sh: return 2;
            op_lw, op_lwu, op_sw: return 4;
            default:              return 8;
        endcase
    endfunction

    function automatic logic is_store(input mem_op_e op);
        return (op == op_sb) || (op == op_sh) || (op == op_sw) || (op == op_sd);
    endfunction

    function automatic logic is_signed_load(input mem_op_e op);
        return (op == op_lb) || (op == op_lh) || (op == op_lw) || (op == op_ld);
    endfunction

    // store bytes placed at their lanes, zero elsewhere
    function automatic logic [entry_bits-1:0] lanes_only(input int off, input int n,
                                                         input logic [entry_bits-1:0] wd);
        logic [entry_bits-1:0] e;
        e = '0;
        for (int k = 0; k < n; k++)
            e[(off+k)*8 +: 8] = wd[k*8 +: 8];
        return e;
    endfunction

    function automatic logic [entry_bits-1:0] load_value(input logic [entry_bits-1:0] entry,
                                                         input int off, input int n,
                                                         input logic sgn);
        logic [entry_bits-1:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
            v[k*8 +: 8] = entry[(off+k)*8 +: 8];
        if (sgn && n < 8 && v[n*8-1])
        begin
            for (int k = n; k < 8; k++)
                v[k*8 +: 8] = 8'hff;
        end
        return v;
    endfunction

    task automatic store_bytes(input int set, input int off, input int n,
                               input logic [entry_bits-1:0] wd);
        for (int k = 0; k < n; k++)
            model_mem[set][(off+k)*8 +: 8] = wd[k*8 +: 8];
        model_written[set] = 1'b1;
    endtask

    task automatic check_port(input string name, input logic valid,
                              input logic [entry_bits-1:0] data, input logic hit,
                              input logic e_valid, input logic [entry_bits-1:0] e_data,
                              input logic e_hit);
        check_count++;
        if (valid !== e_valid)
        begin
            error_count++;
            $display("ERROR at %0t: port %s rsp_valid %b, expected %b", $time, name, valid,
                     e_valid);
        end
        if (hit !== (e_valid && e_hit))
        begin
            error_count++;
            $display("ERROR at %0t: port %s rsp_hit %b, expected %b", $time, name, hit,
                     e_valid && e_hit);
        end
        // data of a never written set is unknown
        if (e_valid && e_hit && data !== e_data)
        begin
            error_count++;
            $display("ERROR at %0t: port %s rsp_data %h, expected %h", $time, name, data,
                     e_data);
        end
    endtask

    task automatic run_cycle(input logic a_en, input mem_op_e a_o,
                             input logic [addr_bits-1:0] a_ad, input logic [entry_bits-1:0] a_wd,
                             input logic b_en, input mem_op_e b_o,
                             input logic [addr_bits-1:0] b_ad, input logic [entry_bits-1:0] b_wd);
        int                    a_set;
        int                    a_n;
        int                    a_off;
        int                    b_set;
        int                    b_n;
        int                    b_off;
        logic                  a_st;
        logic                  b_st;
        logic [entry_bits-1:0] a_src;
        logic [entry_bits-1:0] b_src;
        logic                  a_src_hit;
        logic                  b_src_hit;
        @(posedge clk_in);
        #2;
        check_port("A", a_rsp_valid, a_rsp_data, a_rsp_hit, exp_a_valid, exp_a_data, exp_a_hit);
        check_port("B", b_rsp_valid, b_rsp_data, b_rsp_hit, exp_b_valid, exp_b_data, exp_b_hit);

        a_set = int'(a_ad[addr_bits-1:3]);
        a_n   = size_bytes(a_o);
        a_off = int'(a_ad[2:0]) / a_n * a_n;
        a_st  = a_en && is_store(a_o);
        b_set = int'(b_ad[addr_bits-1:3]);
        b_n   = size_bytes(b_o);
        b_off = int'(b_ad[2:0]) / b_n * b_n;
        b_st  = b_en && is_store(b_o);

        // a load sees a same-cycle store of the other port
        a_src     = model_mem[a_set];
        a_src_hit = model_written[a_set];
        if (b_st && !a_st && b_set == a_set)
        begin
            a_src     = lanes_only(b_off, b_n, b_wd);
            a_src_hit = 1'b1;
        end
        b_src     = model_mem[b_set];
        b_src_hit = model_written[b_set];
        if (a_st && a_set == b_set)
        begin
            b_src     = lanes_only(a_off, a_n, a_wd);
            b_src_hit = 1'b1;
        end

        exp_a_valid = a_en && !a_st;
        exp_a_hit   = a_src_hit;
        exp_a_data  = load_value(a_src, a_off, a_n, is_signed_load(a_o));
        exp_b_valid = b_en && !b_st;
        exp_b_hit   = b_src_hit;
        exp_b_data  = load_value(b_src, b_off, b_n, is_signed_load(b_o));

        if (b_st && !(a_st && a_set == b_set))
            store_bytes(b_set, b_off, b_n, b_wd);
        if (a_st)
            store_bytes(a_set, a_off, a_n, a_wd);

        a_req   = a_en;
        a_op    = a_o;
        a_addr  = a_ad;
        a_wdata = a_wd;
        b_req   = b_en;
        b_op    = b_o;
        b_addr  = b_ad;
        b_wdata = b_wd;
    endtask

    task automatic idle_cycle();
        run_cycle(1'b0, op_lb, '0, '0, 1'b0, op_lb, '0, '0);
    endtask

    initial
    begin
        int set;
        seed        = 33199;
        reset_in    = 1'b1;
        a_req       = 1'b0;
        a_op        = op_lb;
        a_addr      = '0;
        a_wdata     = '0;
        b_req       = 1'b0;
        b_op        = op_lb;
        b_addr      = '0;
        b_wdata     = '0;
        exp_a_valid = 1'b0;
        exp_a_hit   = 1'b0;
        exp_a_data  = '0;
        exp_b_valid = 1'b0;
        exp_b_hit   = 1'b0;
        exp_b_data  = '0;
        for (int s = 0; s < num_sets; s++)
            model_written[s] = 1'b0;
        repeat (2) @(posedge clk_in);
        #2;
        reset_in = 1'b0;

        // nothing written yet, every load misses
        for (int s = 0; s < num_sets; s++)
            run_cycle(1'b1, pick_op(1), make_addr(s, rand_below(8)), '0,
                      1'b1, pick_op(1), make_addr(num_sets - 1 - s, rand_below(8)), '0);

        // collision on a never written set still hits
        for (int s = 0; s < 8; s++)
            if (s % 2 == 0)
                run_cycle(1'b1, pick_op(1), make_addr(s, rand_below(8)), '0,
                          1'b1, pick_op(2), make_addr(s, rand_below(8)), rand_data());
            else
                run_cycle(1'b1, pick_op(2), make_addr(s, rand_below(8)), rand_data(),
                          1'b1, pick_op(1), make_addr(s, rand_below(8)), '0);

        // fill every set from port A, then A stores and two-port loads
        for (int s = 0; s < num_sets; s++)
            run_cycle(1'b1, op_sd, make_addr(s, 0), rand_data(), 1'b0, op_lb, '0, '0);
        repeat (60)
            run_cycle(1'b1, pick_op(2), addr_bits'(rand_word()), rand_data(),
                      1'b0, op_lb, '0, '0);
        repeat (60)
            run_cycle(1'b1, pick_op(1), addr_bits'(rand_word()), '0,
                      1'b1, pick_op(1), addr_bits'(rand_word()), '0);

        // same-set stores on both ports, read back whole entry
        repeat (30)
        begin
            set = rand_below(num_sets);
            run_cycle(1'b1, pick_op(2), make_addr(set, rand_below(8)), rand_data(),
                      1'b1, pick_op(2), make_addr(set, rand_below(8)), rand_data());
            run_cycle(1'b1, op_ld, make_addr(set, 0), '0, 1'b1, op_ld, make_addr(set, 0), '0);
        end

        // load against a same-cycle store on the other port
        repeat (60)
        begin
            set = rand_below(num_sets);
            if (rand_word() & 32'h1)
                run_cycle(1'b1, pick_op(1), make_addr(set, rand_below(8)), '0,
                          1'b1, pick_op(2), make_addr(set, rand_below(8)), rand_data());
            else
                run_cycle(1'b1, pick_op(2), make_addr(set, rand_below(8)), rand_data(),
                          1'b1, pick_op(1), make_addr(set, rand_below(8)), '0);
        end

        // mixed traffic, half of it squeezed onto four sets
        repeat (1000)
        begin
            set = (rand_word() & 32'h1) ? rand_below(4) : rand_below(num_sets);
            run_cycle(rand_below(4) != 0, pick_op(0), make_addr(set, rand_below(8)),
                      rand_data(), rand_below(4) != 0, pick_op(0),
                      (rand_word() & 32'h1) ? make_addr(set, rand_below(8))
                                            : addr_bits'(rand_word()),
                      rand_data());
        end

        idle_cycle();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== sim.f ====
mem_pkg.sv
mem_req_if.sv
access_decoder.sv
dual_port_blockram.sv
load_formatter.sv
scratchpad_top.sv
scratchpad_props.sv
scratchpad_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= scratchpad_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
